// File: audioIfPkg.sv
//--------------------
// host command types
//--------------------
package audioIfPkg;

	// command opcodes as seen on the host side
	typedef enum logic [1:0]
	{
		OpTone,
		OpDuty,
		OpMute
	} toneOpE;

	// one queued tone command, 17 bits
	typedef struct packed
	{
		// what the synthesizer does next period
		toneOpE     op;
		// tone code, drives the phase step
		logic [6:0] note;
		// direct duty, used in OpDuty only
		logic [7:0] duty;
	} toneCmdT;

	// host side credit counter
	// wide enough for any practical queue depth
	typedef logic [7:0] creditCntT;

endpackage

// File: audioSynthPkg.sv
//--------------------
// synthesis math
//--------------------
package audioSynthPkg;

	// fraction bits below the table index
	localparam int PhaseFracBits = 8;

	// phase step width, 1/256 index units
	localparam int StepWidth = 15;

	// step rule: note code plus one, in fraction units
	// note 0 still moves the phase
	function automatic logic [StepWidth-1:0] phaseStep(input logic [6:0] note);
		return StepWidth'(note) + StepWidth'(1);
	endfunction

	// one sine sample, offset to unsigned full scale
	// index runs over one period of 2**sampleWidth points
	function automatic int unsigned sineSample(
		input int unsigned index,
		input int          sampleWidth
	);
		real pi;
		real depth;
		real half;
		real angle;
		pi    = 3.14159265358979;
		depth = real'(1 << sampleWidth);
		// midpoint of the unsigned range
		half  = (real'((1 << sampleWidth) - 1)) / 2.0;
		angle = 2.0 * pi * real'(index) / depth;
		// int cast rounds to nearest
		return int'(half + half * $sin(angle));
	endfunction

endpackage

// File: toneCmdQueue.sv
//--------------------
// tone command queue
//--------------------
`timescale 1ns/1ps

module toneCmdQueue
	import audioIfPkg::*;
#(
	parameter int QueueDepth = 4
)(
	input  logic    audioClk,
	input  logic    rstN,
	input  toneCmdT cmd,
	input  logic    cmdValid,
	input  logic    periodEnd,
	output toneCmdT head,
	output logic    notEmpty,
	output logic    credit
);

	localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CntWidth = $clog2(QueueDepth + 1);

	// circular storage
	toneCmdT             slots [QueueDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CntWidth-1:0] count;
	logic                pop;

	// wrap at depth, also for non power of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(QueueDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	//--------------------
	// status and pop
	//--------------------
	assign notEmpty = (count != '0);
	// one entry per PWM period at most
	assign pop      = periodEnd & notEmpty;
	// head is always the oldest entry
	assign head     = slots[rdPtr];

	//--------------------
	// storage write
	//--------------------
	// host owns the credits, so no full check here
	always_ff @(posedge audioClk)
	begin
		if (cmdValid)
			slots[wrPtr] <= cmd;
	end

	//--------------------
	// pointers, count, credit
	//--------------------
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			// freed slot returns its credit one cycle after pop
			credit <= pop;
			if (cmdValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			// push and pop together leave count alone
			case ({cmdValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: audioToneIndex.sv
//--------------------
// phase accumulator
//--------------------
`timescale 1ns/1ps

module audioToneIndex
	import audioSynthPkg::*;
#(
	parameter int SampleWidth = 8
)(
	input  logic                   audioClk,
	input  logic                   rstN,
	input  logic [6:0]             note,
	input  logic                   toneOn,
	input  logic                   advance,
	output logic [SampleWidth-1:0] index
);

	// integer part is the table index
	localparam int PhaseWidth = SampleWidth + PhaseFracBits;

	logic [PhaseWidth-1:0] phase;
	logic [PhaseWidth-1:0] step;

	// step from the active note
	// truncation only matters for very small tables
	assign step = PhaseWidth'(phaseStep(note));

	//--------------------
	// accumulate
	//--------------------
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
		begin
			phase <= '0;
		end
		else if (!toneOn)
		begin
			// mute or direct duty restarts the wave
			phase <= '0;
		end
		else if (advance)
		begin
			// wraps naturally over one wave period
			phase <= phase + step;
		end
	end

	// drop the fraction bits
	assign index = phase[PhaseWidth-1 -: SampleWidth];

endmodule

// File: waveTableRom.sv
//--------------------
// sine wave table
//--------------------
`timescale 1ns/1ps

module waveTableRom
	import audioSynthPkg::*;
#(
	parameter int SampleWidth = 8
)(
	input  logic                   audioClk,
	input  logic [SampleWidth-1:0] index,
	output logic [SampleWidth-1:0] wave
);

	// one full sine period
	localparam int TableDepth = 1 << SampleWidth;

	logic [SampleWidth-1:0] sineTable [TableDepth];

	// filled at elaboration from the package function
	initial
	begin
		for (int i = 0; i < TableDepth; i++)
			sineTable[i] = SampleWidth'(sineSample(i, SampleWidth));
	end

	// registered read, one cycle lag
	always_ff @(posedge audioClk)
	begin
		wave <= sineTable[index];
	end

endmodule

// File: dutyGenerator.sv
//--------------------
// PWM generator
//--------------------
`timescale 1ns/1ps

module dutyGenerator #(
	parameter int SampleWidth = 8
)(
	input  logic                   audioClk,
	input  logic                   rstN,
	input  logic [SampleWidth-1:0] duty,
	output logic                   pwm,
	output logic                   periodEnd
);

	// free running, 2**SampleWidth clocks per period
	logic [SampleWidth-1:0] periodCnt;
	// duty held for a whole period
	logic [SampleWidth-1:0] dutyReg;

	//--------------------
	// period counter
	//--------------------
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			periodCnt <= '0;
		else
			periodCnt <= periodCnt + 1'b1;
	end

	// last cycle of the period
	assign periodEnd = (periodCnt == '1);

	//--------------------
	// duty latch
	//--------------------
	// cleared so the first period stays low
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			dutyReg <= '0;
		else if (periodEnd)
			dutyReg <= duty;
	end

	// high count per period equals dutyReg
	// full scale gives one low cycle
	assign pwm = (periodCnt < dutyReg);

endmodule

// File: audioTxUnit.sv
//--------------------
// audio tone synth top
//--------------------
`timescale 1ns/1ps

module audioTxUnit
	import audioIfPkg::*;
#(
	parameter int SampleWidth = 8,
	parameter int QueueDepth  = 4
)(
	input  logic    audioClk,
	input  logic    rstN,
	input  toneCmdT cmd,
	input  logic    cmdValid,
	output logic    credit,
	output logic    pwm
);

	toneCmdT                head;
	toneCmdT                activeCmd;
	logic                   notEmpty;
	logic                   periodEnd;
	logic                   toneOn;
	logic [SampleWidth-1:0] toneIndex;
	logic [SampleWidth-1:0] wave;
	logic [SampleWidth-1:0] dutySel;

	//--------------------
	// command queue
	//--------------------
	toneCmdQueue #(
		.QueueDepth (QueueDepth)
	) cmdQueue0 (
		.audioClk  (audioClk),
		.rstN      (rstN),
		.cmd       (cmd),
		.cmdValid  (cmdValid),
		.periodEnd (periodEnd),
		.head      (head),
		.notEmpty  (notEmpty),
		.credit    (credit)
	);

	// active command, swapped only at period end
	// empty queue keeps the last one
	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			activeCmd <= '{op: OpMute, note: '0, duty: '0};
		else if (periodEnd && notEmpty)
			activeCmd <= head;
	end

	//--------------------
	// tone path
	//--------------------
	assign toneOn = (activeCmd.op == OpTone);

	// advances with the note that was active this period
	audioToneIndex #(
		.SampleWidth (SampleWidth)
	) toneIndex0 (
		.audioClk (audioClk),
		.rstN     (rstN),
		.note     (activeCmd.note),
		.toneOn   (toneOn),
		.advance  (periodEnd),
		.index    (toneIndex)
	);

	waveTableRom #(
		.SampleWidth (SampleWidth)
	) waveRom0 (
		.audioClk (audioClk),
		.index    (toneIndex),
		.wave     (wave)
	);

	// duty source per opcode
	always_comb
	begin
		case (activeCmd.op)
			OpTone:  dutySel = wave;
			OpDuty:  dutySel = SampleWidth'(activeCmd.duty);
			// mute and unused code
			default: dutySel = '0;
		endcase
	end

	//--------------------
	// PWM output
	//--------------------
	dutyGenerator #(
		.SampleWidth (SampleWidth)
	) dutyGen0 (
		.audioClk  (audioClk),
		.rstN      (rstN),
		.duty      (dutySel),
		.pwm       (pwm),
		.periodEnd (periodEnd)
	);

endmodule

// File: audioTxUnit_chk.sv
//--------------------
// synth bus checker
//--------------------
`timescale 1ns/1ps

module audioTxUnit_chk
	import audioIfPkg::*;
#(
	parameter int QueueDepth = 4
)(
	input logic audioClk,
	input logic rstN,
	input logic cmdValid,
	input logic credit,
	input logic periodEnd,
	input logic pwm
);

	// commands sent and not yet credited back
	creditCntT   outstanding;
	// failure tally per property
	int unsigned overflowFails = 0;
	int unsigned creditFails   = 0;
	int unsigned riseFails     = 0;
	int unsigned failTotal;

	always_ff @(posedge audioClk or negedge rstN)
	begin
		if (!rstN)
			outstanding <= '0;
		else
			outstanding <= outstanding + creditCntT'(cmdValid) - creditCntT'(credit);
	end

	assign failTotal = overflowFails + creditFails + riseFails;

	//--------------------
	// credit rules
	//--------------------
	// host must still hold a credit
	noOverflow: assert property (@(posedge audioClk) disable iff (!rstN)
		cmdValid |-> outstanding < creditCntT'(QueueDepth))
	else
	begin
		overflowFails++;
		$error("command sent with no credit left");
	end

	// credit only right after a pop of a real entry
	creditAfterPop: assert property (@(posedge audioClk) disable iff (!rstN)
		credit |-> $past(periodEnd) && outstanding != '0)
	else
	begin
		creditFails++;
		$error("credit pulse without a pop");
	end

	//--------------------
	// PWM shape
	//--------------------
	// one pulse per period from the period start
	pwmRiseAtStart: assert property (@(posedge audioClk) disable iff (!rstN)
		$rose(pwm) |-> $past(periodEnd))
	else
	begin
		riseFails++;
		$error("pwm rose inside a period");
	end

endmodule

bind audioTxUnit audioTxUnit_chk #(
	.QueueDepth (QueueDepth)
) chk0 (
	.audioClk  (audioClk),
	.rstN      (rstN),
	.cmdValid  (cmdValid),
	.credit    (credit),
	.periodEnd (periodEnd),
	.pwm       (pwm)
);

// File: tbAudioTxUnit.sv
//--------------------
// audio synth testbench
//--------------------
`timescale 1ns/1ps

module tbAudioTxUnit
	import audioIfPkg::*, audioSynthPkg::*;
();

	localparam int SampleWidth = 8;
	localparam int QueueDepth  = 4;
	localparam int PeriodLen   = 1 << SampleWidth;
	localparam int PhaseWidth  = SampleWidth + PhaseFracBits;

	logic    audioClk;
	logic    rstN;
	toneCmdT cmd;
	logic    cmdValid;
	logic    credit;
	logic    pwm;

	// host side model
	toneCmdT               modelQ [$];
	toneCmdT               activeCmd;
	logic [PhaseWidth-1:0] modelPhase;
	logic [31:0]           lfsr;
	logic                  expCredit;
	int                    expDuty;
	int                    highCnt;
	int                    phaseCnt;
	int                    periodNum;
	int                    hostCredits;

	audioTxUnit dut0 (
		.audioClk (audioClk),
		.rstN     (rstN),
		.cmd      (cmd),
		.cmdValid (cmdValid),
		.credit   (credit),
		.pwm      (pwm)
	);

	initial
	begin
		audioClk = 1'b0;
		forever
			#50 audioClk = ~audioClk;
	end

	// galois step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	task automatic valueError(input string msg);
		abortRun($sformatf("[ERROR] %0t %s", $time, msg));
	endtask

	//--------------------
	// period model
	//--------------------
	// period end edge: check count, then step duty, phase, queue
	task automatic closePeriod();
		int nextDuty;
		assert (highCnt == expDuty)
		else
			valueError($sformatf("period %0d high count %0d, expected %0d",
				periodNum, highCnt, expDuty));
		// ROM output at period end reflects this period's index
		case (activeCmd.op)
			OpTone:  nextDuty = int'(sineSample(modelPhase[PhaseWidth-1 -: SampleWidth],
				SampleWidth));
			OpDuty:  nextDuty = int'(activeCmd.duty);
			default: nextDuty = 0;
		endcase
		// phase steps on the old note, restarts when not in tone
		if (activeCmd.op == OpTone)
			modelPhase = modelPhase + PhaseWidth'(phaseStep(activeCmd.note));
		else
			modelPhase = '0;
		expDuty = nextDuty;
		// pop sees queue state before this edge's push
		if (modelQ.size() > 0)
		begin
			activeCmd = modelQ.pop_front();
			expCredit = 1'b1;
		end
		highCnt = 0;
		periodNum++;
	endtask

	// one clock, returns at the next drive point
	task automatic runCycle();
		@(negedge audioClk);
		assert (credit == expCredit)
		else
			valueError($sformatf("credit %0b, expected %0b", credit, expCredit));
		assert (dut0.chk0.failTotal == 0)
		else
			abortRun("bound checker reported an assertion failure");
		highCnt += int'(pwm);
		if (credit)
			hostCredits++;
		@(posedge audioClk);
		expCredit = 1'b0;
		if (phaseCnt == PeriodLen - 1)
			closePeriod();
		if (cmdValid)
			modelQ.push_back(cmd);
		phaseCnt = (phaseCnt + 1) % PeriodLen;
		#1;
		cmdValid = 1'b0;
	endtask

	task automatic waitForCredit();
		int waited;
		waited = 0;
		while (hostCredits == 0)
		begin
			runCycle();
			waited++;
			if (waited > 2 * PeriodLen)
				abortRun("timed out waiting for a credit from the queue");
		end
	endtask

	// all slots free again
	task automatic drainQueue();
		int waited;
		waited = 0;
		while (hostCredits < QueueDepth)
		begin
			runCycle();
			waited++;
			if (waited > (QueueDepth + 2) * PeriodLen)
				abortRun("timed out waiting for all credits to return");
		end
	endtask

	task automatic sendCmd(input toneOpE opSel, input logic [6:0] noteVal,
		input logic [7:0] dutyVal);
		waitForCredit();
		cmd      = '{op: opSel, note: noteVal, duty: dutyVal};
		cmdValid = 1'b1;
		hostCredits--;
		runCycle();
	endtask

	//--------------------
	// stimulus
	//--------------------
	initial
	begin
		int         gap;
		logic [1:0] opBits;
		toneOpE     opSel;
		logic [6:0] noteVal;
		logic [7:0] dutyVal;
		lfsr        = 32'h91c8_2ff9;
		rstN        = 1'b0;
		cmdValid    = 1'b0;
		cmd         = '{op: OpMute, note: '0, duty: '0};
		activeCmd   = '{op: OpMute, note: '0, duty: '0};
		modelPhase  = '0;
		expCredit   = 1'b0;
		expDuty     = 0;
		highCnt     = 0;
		phaseCnt    = 0;
		periodNum   = 0;
		hostCredits = QueueDepth;
		// outputs quiet in reset
		repeat (5)
		begin
			@(negedge audioClk);
			assert (!pwm && !credit)
			else
				valueError("pwm or credit high during reset");
			@(posedge audioClk);
		end
		#1;
		rstN = 1'b1;
		// back to back fill, mute between tones
		sendCmd(OpDuty, 7'd0, 8'h5a);
		sendCmd(OpTone, 7'd20, 8'h00);
		sendCmd(OpMute, 7'd0, 8'h00);
		sendCmd(OpTone, 7'd127, 8'h00);
		// empty queue holds the last tone
		drainQueue();
		repeat (4 * PeriodLen)
			runCycle();
		// random gaps and commands, tone weighted
		for (int n = 0; n < 24; n++)
		begin
			gap = int'(randBits(9));
			repeat (gap)
				runCycle();
			opBits  = 2'(randBits(2));
			noteVal = 7'(randBits(7));
			dutyVal = 8'(randBits(8));
			case (opBits)
				2'd0:    opSel = OpDuty;
				2'd1:    opSel = OpMute;
				default: opSel = OpTone;
			endcase
			sendCmd(opSel, noteVal, dutyVal);
		end
		drainQueue();
		repeat (3 * PeriodLen)
			runCycle();
		if (dut0.chk0.failTotal == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			abortRun("bound checker reported an assertion failure");
	end

endmodule

// File: vlog.f
audioIfPkg.sv
audioSynthPkg.sv
toneCmdQueue.sv
audioToneIndex.sv
waveTableRom.sv
dutyGenerator.sv
audioTxUnit.sv
audioTxUnit_chk.sv
tbAudioTxUnit.sv

// File: Bender.yml
package:
  name: audioTxUnit

sources:
  - audioIfPkg.sv
  - audioSynthPkg.sv
  - toneCmdQueue.sv
  - audioToneIndex.sv
  - waveTableRom.sv
  - dutyGenerator.sv
  - audioTxUnit.sv
  - target: simulation
    files:
      - audioTxUnit_chk.sv
      - tbAudioTxUnit.sv
